// ==== compile.f ====
common/filter_pkg.sv
verilog/query_req.sv
verilog/seq_queue.sv
data_filter/lane_split.sv
data_filter/match_lane.sv
data_filter/lane_merge.sv
verilog/filter_top.sv
dv/filter_tb.sv

// ==== Bender.yml ====
package:
  name: record_filter

sources:
  # package first, then leaf blocks, then the top level
  - common/filter_pkg.sv
  - verilog/query_req.sv
  - verilog/seq_queue.sv
  - data_filter/lane_split.sv
  - data_filter/match_lane.sv
  - data_filter/lane_merge.sv
  - verilog/filter_top.sv
  - target: test
    files:
      - dv/filter_tb.sv

// ==== dv/filter_tb.sv ====
`timescale 1ns/10ps

module filter_tb import filter_pkg::*; ();

    // records across all tests, sets the watchdog limit
    localparam int total_recs  = 68;
    localparam int cycle_limit = total_recs * 8 + 1000;

    logic aclk, rst_n, query_valid, query_ready, cnfg_valid, rd_valid, rd_ready;
    logic card_valid, card_ready, card_last, res_valid, res_ready, cpl_valid, cpl_ready;
    logic [addr_bits-1:0] query_vaddr, rd_vaddr;
    logic [len_bits-1:0]  query_len, rd_len, cpl_count;
    logic [qp_bits-1:0]   query_qp, cpl_qp;
    logic [rec_bits-1:0]  card_data, res_data;
    cnfg_word_u           cnfg_word;

    // card memory image, one record per 8-byte address
    logic [rec_bits-1:0] mem [256];
    logic [addr_bits-1:0] card_addr_q[$], rd_addr_got[$], rd_addr_exp[$];
    logic [len_bits-1:0]  card_len_q[$], rd_len_got[$], rd_len_exp[$];
    logic [rec_bits-1:0]  res_got[$], res_exp[$];
    logic [qp_bits-1:0]   cpl_qp_got[$], cpl_qp_exp[$];
    logic [len_bits-1:0]  cpl_cnt_got[$], cpl_cnt_exp[$];
    // model of the filter settings
    logic [7:0] mdl_pat0 = '0, mdl_pat1 = '0;
    logic [1:0] mdl_care = '0;
    int mdl_limit = 0;
    int seed, beat_idx, beats_left, cycles, tests_run, tests_bad, total_errs;
    logic stall_en;
    logic [31:0] rnd;

    filter_top i_filter_top (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // card responder, answers requests in order
    always @(posedge aclk) begin
        if (rd_valid && rd_ready) begin
            card_addr_q.push_back(rd_vaddr);
            card_len_q.push_back(rd_len);
            rd_addr_got.push_back(rd_vaddr);
            rd_len_got.push_back(rd_len);
        end
        if (!card_valid || card_ready) begin
            if (beats_left == 0 && card_len_q.size() != 0) begin
                beat_idx   = int'(card_addr_q.pop_front() >> 3);
                beats_left = card_len_q.pop_front();
            end
            if (beats_left != 0) begin
                card_valid <= 1'b1;
                card_data  <= mem[beat_idx & 255];
                card_last  <= beats_left == 1;
                beat_idx++;
                beats_left--;
            end else begin
                card_valid <= 1'b0;
            end
        end
    end

    // output collection plus random result back-pressure
    always @(posedge aclk) begin
        if (res_valid && res_ready) res_got.push_back(res_data);
        if (cpl_valid && cpl_ready) begin
            cpl_qp_got.push_back(cpl_qp);
            cpl_cnt_got.push_back(cpl_count);
        end
        rnd = $random(seed);
        res_ready <= !stall_en || rnd[0];
    end

    // watchdog
    always @(posedge aclk) begin
        cycles++;
        if (cycles == cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // two-byte match at any start 0..6, uncared byte matches anything
    function automatic logic rec_match(input logic [rec_bits-1:0] rec);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < scan_steps; i++) begin
            if ((!mdl_care[0] || rec[8*i +: 8] == mdl_pat0) &&
                (!mdl_care[1] || rec[8*i+8 +: 8] == mdl_pat1)) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic plant(input int idx, input int pos, input logic [7:0] b0, input logic [7:0] b1);
        mem[idx][8*pos +: 8]   = b0;
        mem[idx][8*pos+8 +: 8] = b1;
    endtask

    task automatic write_cnfg(input cnfg_word_u w);
        @(posedge aclk);
        cnfg_valid <= 1'b1;
        cnfg_word  <= w;
        @(posedge aclk);
        cnfg_valid <= 1'b0;
    endtask

    task automatic set_pattern(input logic [7:0] p0, input logic [7:0] p1, input logic [1:0] c);
        cnfg_word_u w;
        w = '0;
        w.pat.op   = op_pattern;
        w.pat.pat0 = p0;
        w.pat.pat1 = p1;
        w.pat.care = c;
        mdl_pat0 = p0;
        mdl_pat1 = p1;
        mdl_care = c;
        write_cnfg(w);
    endtask

    task automatic set_limit(input int lim);
        cnfg_word_u w;
        w = '0;
        w.lim.op    = op_limit;
        w.lim.limit = len_bits'(lim);
        mdl_limit = lim;
        write_cnfg(w);
    endtask

    // model the query, then hand it to the DUT
    task automatic run_query(input int base, input int len, input logic [qp_bits-1:0] qp);
        int cnt;
        cnt = 0;
        for (int i = base; i < base + len; i++) begin
            if (rec_match(mem[i]) && (mdl_limit == 0 || cnt < mdl_limit)) begin
                res_exp.push_back(mem[i]);
                cnt++;
            end
        end
        cpl_qp_exp.push_back(qp);
        cpl_cnt_exp.push_back(len_bits'(cnt));
        rd_addr_exp.push_back(addr_bits'(base * 8));
        rd_len_exp.push_back(len_bits'(len));
        @(posedge aclk);
        query_valid <= 1'b1;
        query_vaddr <= addr_bits'(base * 8);
        query_len   <= len_bits'(len);
        query_qp    <= qp;
        forever begin
            @(posedge aclk);
            if (query_ready) break;
        end
        query_valid <= 1'b0;
    endtask

    // wait for all completions, compare everything, report one line
    task automatic finish_test(input string name);
        int errs;
        errs = 0;
        while (cpl_qp_got.size() < cpl_qp_exp.size()) @(posedge aclk);
        // room for stray extra results
        repeat (20) @(posedge aclk);
        assert (res_got.size() == res_exp.size()) else begin
            $display("FAIL %0t: %s result count %0d, want %0d",
                     $time, name, res_got.size(), res_exp.size());
            errs++;
        end
        for (int i = 0; i < res_got.size() && i < res_exp.size(); i++) begin
            assert (res_got[i] == res_exp[i]) else begin
                $display("FAIL %0t: %s result %0d is %h, want %h",
                         $time, name, i, res_got[i], res_exp[i]);
                errs++;
            end
        end
        assert (cpl_qp_got.size() == cpl_qp_exp.size()) else begin
            $display("FAIL %0t: %s extra completions", $time, name);
            errs++;
        end
        for (int i = 0; i < cpl_qp_exp.size() && i < cpl_qp_got.size(); i++) begin
            assert (cpl_qp_got[i] == cpl_qp_exp[i] && cpl_cnt_got[i] == cpl_cnt_exp[i]) else begin
                $display("FAIL %0t: %s completion %0d qp %h count %0d, want qp %h count %0d",
                         $time, name, i, cpl_qp_got[i], cpl_cnt_got[i],
                         cpl_qp_exp[i], cpl_cnt_exp[i]);
                errs++;
            end
        end
        for (int i = 0; i < rd_addr_exp.size(); i++) begin
            assert (i < rd_addr_got.size() && rd_addr_got[i] == rd_addr_exp[i] &&
                    rd_len_got[i] == rd_len_exp[i]) else begin
                $display("FAIL %0t: %s read request %0d wrong address or length", $time, name, i);
                errs++;
            end
        end
        $display("%s: %0d mismatches", name, errs);
        tests_run++;
        if (errs != 0) tests_bad++;
        total_errs += errs;
        res_got.delete();
        res_exp.delete();
        cpl_qp_got.delete();
        cpl_qp_exp.delete();
        cpl_cnt_got.delete();
        cpl_cnt_exp.delete();
        rd_addr_got.delete();
        rd_addr_exp.delete();
        rd_len_got.delete();
        rd_len_exp.delete();
    endtask

    // reset values match every record
    task automatic test_no_config();
        run_query(0, 6, 24'h000101);
        finish_test("no_config");
    endtask

    task automatic test_full_care();
        plant(17, 0, 8'ha5, 8'h3c);
        plant(20, 6, 8'ha5, 8'h3c);
        plant(24, 3, 8'ha5, 8'h3c);
        // near miss, second byte off by one
        plant(22, 2, 8'ha5, 8'h3d);
        set_pattern(8'ha5, 8'h3c, 2'b11);
        run_query(16, 10, 24'h000202);
        finish_test("full_care");
    endtask

    task automatic test_wildcard();
        plant(33, 1, 8'h5a, 8'h00);
        plant(38, 6, 8'h5a, 8'hff);
        // byte 7 is no start position
        mem[40][63:56] = 8'h5a;
        set_pattern(8'h5a, 8'h11, 2'b01);
        run_query(32, 10, 24'h000303);
        finish_test("wildcard");
    endtask

    task automatic test_limit();
        set_pattern(8'h00, 8'h00, 2'b00);
        set_limit(2);
        run_query(48, 5, 24'h000404);
        run_query(56, 5, 24'h000405);
        finish_test("limit");
        set_limit(0);
    endtask

    task automatic test_backpressure();
        @(posedge aclk);
        stall_en <= 1'b1;
        run_query(64, 20, 24'h000506);
        finish_test("backpressure");
        @(posedge aclk);
        stall_en <= 1'b0;
    endtask

    task automatic test_back_to_back();
        plant(97, 2, 8'hc3, 8'h7e);
        plant(106, 5, 8'hc3, 8'h7e);
        plant(108, 0, 8'hc3, 8'h7e);
        set_pattern(8'hc3, 8'h7e, 2'b11);
        run_query(96, 6, 24'h000607);
        run_query(104, 6, 24'h000608);
        finish_test("back_to_back");
    endtask

    initial begin
        seed = 32'h54f1;
        rst_n = 1'b0;
        query_valid = 1'b0;
        query_vaddr = '0;
        query_len = '0;
        query_qp = '0;
        cnfg_valid = 1'b0;
        cnfg_word = '0;
        rd_ready = 1'b1;
        card_valid = 1'b0;
        card_data = '0;
        card_last = 1'b0;
        res_ready = 1'b1;
        cpl_ready = 1'b1;
        stall_en = 1'b0;
        beats_left = 0;
        cycles = 0;
        tests_run = 0;
        tests_bad = 0;
        total_errs = 0;
        for (int i = 0; i < 256; i++) mem[i] = {$random(seed), $random(seed)};
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;
        test_no_config();
        test_full_care();
        test_wildcard();
        test_limit();
        test_backpressure();
        test_back_to_back();
        $display("tests %0d, with errors %0d, mismatches %0d", tests_run, tests_bad, total_errs);
        if (tests_bad == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/filter_top.sv ====
`timescale 1ns/10ps

module filter_top import filter_pkg::*; (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  logic                 query_valid,
    output logic                 query_ready,
    input  logic [addr_bits-1:0] query_vaddr,
    input  logic [len_bits-1:0]  query_len,
    input  logic [qp_bits-1:0]   query_qp,
    input  logic                 cnfg_valid,
    input  cnfg_word_u           cnfg_word,
    output logic                 rd_valid,
    input  logic                 rd_ready,
    output logic [addr_bits-1:0] rd_vaddr,
    output logic [len_bits-1:0]  rd_len,
    input  logic                 card_valid,
    output logic                 card_ready,
    input  logic [rec_bits-1:0]  card_data,
    input  logic                 card_last,
    output logic                 res_valid,
    input  logic                 res_ready,
    output logic [rec_bits-1:0]  res_data,
    output logic                 cpl_valid,
    input  logic                 cpl_ready,
    output logic [qp_bits-1:0]   cpl_qp,
    output logic [len_bits-1:0]  cpl_count
);

    // request side to queue
    logic                   push_valid;
    logic                   push_ready;
    logic [params_bits-1:0] push_params;
    // queue to completion logic
    logic                   pop_valid;
    logic                   pop_ready;
    logic [params_bits-1:0] pop_params;
    // current filter settings
    logic [7:0]             pat0;
    logic [7:0]             pat1;
    logic [1:0]             care;
    logic [len_bits-1:0]    limit;
    // split to lanes, record bus shared
    logic [n_lanes-1:0]     in_valid;
    logic [n_lanes-1:0]     in_ready;
    logic [rec_bits-1:0]    in_rec;
    logic                   in_last;
    // lanes to merge
    logic [n_lanes-1:0]                done_valid;
    logic [n_lanes-1:0]                done_ready;
    logic [n_lanes-1:0]                done_hit;
    logic [n_lanes-1:0][rec_bits-1:0]  done_rec;
    logic [n_lanes-1:0]                done_last;

    query_req i_query_req (
        .aclk, .rst_n,
        .query_valid, .query_ready, .query_vaddr, .query_len, .query_qp,
        .cnfg_valid, .cnfg_word,
        .rd_valid, .rd_ready, .rd_vaddr, .rd_len,
        .push_valid, .push_ready, .push_params,
        .pat0, .pat1, .care, .limit
    );

    seq_queue i_seq_queue (
        .aclk, .rst_n,
        .push_valid, .push_ready, .push_params,
        .pop_valid, .pop_ready, .pop_params
    );

    lane_split i_lane_split (
        .aclk, .rst_n,
        .card_valid, .card_ready, .card_data, .card_last,
        .in_valid, .in_ready, .in_rec, .in_last
    );

    for (genvar k = 0; k < n_lanes; k++) begin : g_lane
        match_lane i_match_lane (
            .aclk, .rst_n,
            .in_valid   (in_valid[k]),
            .in_ready   (in_ready[k]),
            .in_rec, .in_last,
            .pat0, .pat1, .care,
            .done_valid (done_valid[k]),
            .done_ready (done_ready[k]),
            .done_hit   (done_hit[k]),
            .done_rec   (done_rec[k]),
            .done_last  (done_last[k])
        );
    end

    lane_merge i_lane_merge (
        .aclk, .rst_n,
        .done_valid, .done_ready, .done_hit, .done_rec, .done_last,
        .limit,
        .pop_valid, .pop_ready, .pop_params,
        .res_valid, .res_ready, .res_data,
        .cpl_valid, .cpl_ready, .cpl_qp, .cpl_count
    );

endmodule

// ==== data_filter/lane_merge.sv ====
`timescale 1ns/10ps

module lane_merge import filter_pkg::*; (
    input  logic                              aclk,
    input  logic                              rst_n,
    input  logic [n_lanes-1:0]                done_valid,
    output logic [n_lanes-1:0]                done_ready,
    input  logic [n_lanes-1:0]                done_hit,
    input  logic [n_lanes-1:0][rec_bits-1:0]  done_rec,
    input  logic [n_lanes-1:0]                done_last,
    input  logic [len_bits-1:0]               limit,
    input  logic                              pop_valid,
    output logic                              pop_ready,
    input  logic [params_bits-1:0]            pop_params,
    output logic                              res_valid,
    input  logic                              res_ready,
    output logic [rec_bits-1:0]               res_data,
    output logic                              cpl_valid,
    input  logic                              cpl_ready,
    output logic [qp_bits-1:0]                cpl_qp,
    output logic [len_bits-1:0]               cpl_count
);

    logic [lane_bits-1:0] ptr;
    logic [len_bits-1:0]  count;
    // last record taken, completion not yet out
    logic                 cpl_pend;
    logic                 take;
    logic                 fwd;
    logic                 cpl_fire;

    // result slot must be free before a lane is drained
    assign take = done_valid[ptr] && !cpl_pend && (!res_valid || res_ready);
    // hits past a nonzero limit are dropped
    assign fwd  = done_hit[ptr] && (limit == '0 || count < limit);
    // completion waits until every result is accepted
    assign pop_ready = cpl_pend && !res_valid && !cpl_valid;
    assign cpl_fire  = pop_ready && pop_valid;

    always_comb begin
        done_ready      = '0;
        done_ready[ptr] = take;
    end

    always_ff @(posedge aclk) begin
        if (take && fwd) res_data <= done_rec[ptr];
        if (cpl_fire) begin
            // qp sits in the low bits of the entry
            cpl_qp    <= pop_params[qp_bits-1:0];
            cpl_count <= count;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ptr       <= '0;
            count     <= '0;
            cpl_pend  <= 1'b0;
            res_valid <= 1'b0;
            cpl_valid <= 1'b0;
        end else begin
            if (res_ready) res_valid <= 1'b0;
            if (cpl_ready) cpl_valid <= 1'b0;
            if (take) begin
                ptr <= ptr + 1'b1;
                if (fwd) begin
                    res_valid <= 1'b1;
                    count     <= count + 1'b1;
                end
                if (done_last[ptr]) cpl_pend <= 1'b1;
            end
            if (cpl_fire) begin
                cpl_valid <= 1'b1;
                cpl_pend  <= 1'b0;
                // next query counts from zero
                count     <= '0;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!rst_n)
        cpl_valid && limit != '0 |-> cpl_count <= limit);

endmodule

// ==== data_filter/match_lane.sv ====
`timescale 1ns/10ps

module match_lane import filter_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [rec_bits-1:0] in_rec,
    input  logic                in_last,
    input  logic [7:0]          pat0,
    input  logic [7:0]          pat1,
    input  logic [1:0]          care,
    output logic                done_valid,
    input  logic                done_ready,
    output logic                done_hit,
    output logic [rec_bits-1:0] done_rec,
    output logic                done_last
);

    logic                 busy;
    logic [step_bits-1:0] step;
    logic [7:0]           pat0_q;
    logic [7:0]           pat1_q;
    logic [1:0]           care_q;
    logic [7:0]           byte_a;
    logic [7:0]           byte_b;
    logic                 step_hit;

    // free only when neither scanning nor holding a result
    assign in_ready = !busy && !done_valid;

    // bytes step and step+1 of the held record
    assign byte_a   = done_rec[8*step +: 8];
    assign byte_b   = done_rec[8*(step+1) +: 8];
    // masked-off byte always matches
    assign step_hit = (!care_q[0] || byte_a == pat0_q) && (!care_q[1] || byte_b == pat1_q);

    // record and a snapshot of the pattern
    always_ff @(posedge aclk) begin
        if (in_valid && in_ready) begin
            done_rec  <= in_rec;
            done_last <= in_last;
            pat0_q    <= pat0;
            pat1_q    <= pat1;
            care_q    <= care;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            step       <= '0;
            done_hit   <= 1'b0;
            done_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            busy     <= 1'b1;
            step     <= '0;
            done_hit <= 1'b0;
        end else if (busy) begin
            // one start position per cycle
            done_hit <= done_hit | step_hit;
            step     <= step + 1'b1;
            if (step == step_bits'(scan_steps - 1)) begin
                busy       <= 1'b0;
                done_valid <= 1'b1;
            end
        end else if (done_ready) begin
            done_valid <= 1'b0;
        end
    end

    assert property (@(posedge aclk) disable iff (!rst_n)
        busy |-> step < step_bits'(scan_steps));

endmodule

// ==== data_filter/lane_split.sv ====
`timescale 1ns/10ps

module lane_split import filter_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                card_valid,
    output logic                card_ready,
    input  logic [rec_bits-1:0] card_data,
    input  logic                card_last,
    output logic [n_lanes-1:0]  in_valid,
    input  logic [n_lanes-1:0]  in_ready,
    output logic [rec_bits-1:0] in_rec,
    output logic                in_last
);

    logic [lane_bits-1:0] ptr;

    // wait for the pointed lane, never skip one
    assign card_ready = in_ready[ptr];
    // record bus is shared, only the pointed lane sees valid
    assign in_rec  = card_data;
    assign in_last = card_last;

    always_comb begin
        in_valid      = '0;
        in_valid[ptr] = card_valid;
    end

    // advance on every accepted record
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (card_valid && card_ready) begin
            ptr <= ptr + 1'b1;
        end
    end

    // a record waiting on a busy lane is held unchanged at the card side
    assert property (@(posedge aclk) disable iff (!rst_n)
        card_valid && !card_ready |=> card_valid && $stable(card_data) && $stable(card_last));

endmodule

// ==== verilog/seq_queue.sv ====
`timescale 1ns/10ps

module seq_queue import filter_pkg::*; (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   push_valid,
    output logic                   push_ready,
    input  logic [params_bits-1:0] push_params,
    output logic                   pop_valid,
    input  logic                   pop_ready,
    output logic [params_bits-1:0] pop_params
);

    logic [params_bits-1:0]  mem [seq_depth];
    logic [seq_ptr_bits-1:0] wr_ptr;
    logic [seq_ptr_bits-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [seq_ptr_bits:0]   count;
    logic                    push_fire;
    logic                    pop_fire;

    assign push_ready = count != (seq_ptr_bits + 1)'(seq_depth);
    assign pop_valid  = count != '0;
    assign pop_params = mem[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    always_ff @(posedge aclk) begin
        if (push_fire) mem[wr_ptr] <= push_params;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= wr_ptr + 1'b1;
            if (pop_fire) rd_ptr <= rd_ptr + 1'b1;
            count <= count + push_fire - pop_fire;
        end
    end

    // a full queue holds off the request side until it drains
    assert property (@(posedge aclk) disable iff (!rst_n)
        push_valid && !push_ready |=> push_valid && $stable(push_params));
    // params are pushed long before the query's last record drains
    assert property (@(posedge aclk) disable iff (!rst_n) pop_ready |-> pop_valid);

endmodule

// ==== verilog/query_req.sv ====
`timescale 1ns/10ps

module query_req import filter_pkg::*; (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   query_valid,
    output logic                   query_ready,
    input  logic [addr_bits-1:0]   query_vaddr,
    input  logic [len_bits-1:0]    query_len,
    input  logic [qp_bits-1:0]     query_qp,
    input  logic                   cnfg_valid,
    input  cnfg_word_u             cnfg_word,
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output logic [addr_bits-1:0]   rd_vaddr,
    output logic [len_bits-1:0]    rd_len,
    output logic                   push_valid,
    input  logic                   push_ready,
    output logic [params_bits-1:0] push_params,
    output logic [7:0]             pat0,
    output logic [7:0]             pat1,
    output logic [1:0]             care,
    output logic [len_bits-1:0]    limit
);

    logic [qp_bits-1:0] qp_q;
    logic               query_fire;

    assign query_fire = query_valid && query_ready;
    // queue entry packs address, length and qp
    assign push_params = {rd_vaddr, rd_len, qp_q};

    // query payload, stable while either handshake is open
    always_ff @(posedge aclk) begin
        if (query_fire) begin
            rd_vaddr <= query_vaddr;
            rd_len   <= query_len;
            qp_q     <= query_qp;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid    <= 1'b0;
            push_valid  <= 1'b0;
            query_ready <= 1'b0;
        end else if (query_fire) begin
            // request and push both open next cycle
            rd_valid    <= 1'b1;
            push_valid  <= 1'b1;
            query_ready <= 1'b0;
        end else begin
            if (rd_ready) rd_valid <= 1'b0;
            if (push_ready) push_valid <= 1'b0;
            // reopen once both sides are done
            query_ready <= (!rd_valid || rd_ready) && (!push_valid || push_ready);
        end
    end

    // config decode, takes effect for the next record into a lane
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pat0  <= '0;
            pat1  <= '0;
            care  <= '0;
            limit <= '0;
        end else if (cnfg_valid) begin
            case (cnfg_word.pat.op)
                op_pattern: begin
                    pat0 <= cnfg_word.pat.pat0;
                    pat1 <= cnfg_word.pat.pat1;
                    care <= cnfg_word.pat.care;
                end
                op_limit: limit <= cnfg_word.lim.limit;
                default: ;
            endcase
        end
    end

    // zero length would leave the completion waiting on a last record
    assert property (@(posedge aclk) disable iff (!rst_n) rd_valid |-> rd_len != '0);

endmodule

// ==== common/filter_pkg.sv ====
package filter_pkg;

    // query parameters as carried through the sequence queue
    localparam int addr_bits   = 48;
    localparam int len_bits    = 16;
    localparam int qp_bits     = 24;
    localparam int params_bits = addr_bits + len_bits + qp_bits;

    // record path
    localparam int rec_bits   = 64;
    localparam int n_lanes    = 4;
    localparam int lane_bits  = $clog2(n_lanes);
    // a two-byte pattern can start at bytes 0..6 of an 8-byte record
    localparam int scan_steps = rec_bits / 8 - 1;
    localparam int step_bits  = $clog2(scan_steps + 1);

    // in-order queue between request and data side
    localparam int seq_depth    = 4;
    localparam int seq_ptr_bits = $clog2(seq_depth);

    // opcode in bits 63:62 of a config word
    typedef enum logic [1:0] {
        op_pattern = 2'd1,
        op_limit   = 2'd2
    } cnfg_op_e;

    // one config word, decoded by its opcode
    typedef union packed {
        struct packed {
            cnfg_op_e    op;
            logic [43:0] rsvd;
            logic [7:0]  pat0;
            logic [7:0]  pat1;
            // bit 0 cares about pat0, bit 1 about pat1
            logic [1:0]  care;
        } pat;
        struct packed {
            cnfg_op_e            op;
            logic [45:0]         rsvd;
            // 0 means no limit
            logic [len_bits-1:0] limit;
        } lim;
    } cnfg_word_u;

endpackage
